/* src/ddr_config.svh */
`ifndef DDR_CONFIG_SVH
`define DDR_CONFIG_SVH

// Data path
`define DDR_WORD_W 64
`define DDR_BE_W 8

// Request address as seen by the master
`define DDR_ADDR_W 29

// Only the low address bits select a stored word, so the upper ones alias
`define DDR_MEM_AW 10

// Burst length field
`define DDR_BURST_W 8

// Edges from accept to first read beat
`define DDR_READ_LATENCY 16

// Idle cycles between accept slots
`define DDR_ACCEPT_PERIOD 8

`endif

/* src/ddr_bus_pkg.sv */
`default_nettype none
`include "ddr_config.svh"

package ddr_bus_pkg;

    // One 64-bit data word
    typedef logic [`DDR_WORD_W-1:0] word_t;

    // Bit i enables byte i of a word
    typedef logic [`DDR_BE_W-1:0] be_t;

    // Full request address
    typedef logic [`DDR_ADDR_W-1:0] addr_t;

    // Index of a stored word
    typedef logic [`DDR_MEM_AW-1:0] mem_addr_t;

    // Number of beats in a burst
    typedef logic [`DDR_BURST_W-1:0] burst_t;

endpackage

`default_nettype wire

/* src/ddr_ctrl_pkg.sv */
`default_nettype none

package ddr_ctrl_pkg;

    // Burst controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WRITE = 2'd1,
        ST_WAIT  = 2'd2,
        ST_READ  = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/ddr_mem_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_config.svh"

module ddr_mem_array (
    input  wire                          clk,
    input  wire ddr_bus_pkg::mem_addr_t  mem_addr,
    input  wire                          mem_wr,
    input  wire ddr_bus_pkg::word_t      din,
    input  wire ddr_bus_pkg::be_t        be,
    output ddr_bus_pkg::word_t           dout
);

    localparam int DEPTH = 1 << `DDR_MEM_AW;

    ddr_bus_pkg::word_t mem [DEPTH];

    // Byte-masked write, untouched lanes keep their old contents
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            for (int i = 0; i < `DDR_BE_W; i++) begin
                if (be[i]) begin
                    mem[mem_addr][8*i +: 8] <= din[8*i +: 8];
                end
            end
        end
    end

    // Zero-latency read
    assign dout = mem[mem_addr];

endmodule

`default_nettype wire

/* src/ddr_burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_config.svh"

module ddr_burst_ctrl (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rd,
    input  wire                          we,
    input  wire ddr_bus_pkg::addr_t      addr,
    input  wire ddr_bus_pkg::burst_t     burstcnt,
    output logic                         busy,
    output logic                         dout_ready,
    output ddr_bus_pkg::mem_addr_t       mem_addr,
    output logic                         mem_wr
);

    localparam int WIN_W = $clog2(`DDR_ACCEPT_PERIOD);
    localparam int LAT_W = $clog2(`DDR_READ_LATENCY);

    // Last window count before it wraps to the accept slot
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`DDR_ACCEPT_PERIOD - 1);

    // Loaded at accept, so the first beat lands on edge DDR_READ_LATENCY
    localparam logic [LAT_W-1:0] LAT_LOAD = LAT_W'(`DDR_READ_LATENCY - 1);

    ddr_ctrl_pkg::ctrl_state_t state;
    logic [WIN_W-1:0]          win_cnt;
    logic [LAT_W-1:0]          lat_cnt;
    ddr_bus_pkg::burst_t       beats_left;
    logic                      accept;
    logic                      last_beat;

    // Requests are only taken in the idle slot of the window
    assign busy      = !((state == ddr_ctrl_pkg::ST_IDLE) && (win_cnt == '0));
    assign accept    = (rd || we) && !busy;
    assign last_beat = (beats_left == ddr_bus_pkg::burst_t'(1));

    assign mem_wr     = (state == ddr_ctrl_pkg::ST_WRITE);
    assign dout_ready = (state == ddr_ctrl_pkg::ST_READ);

    // Free-running window, starts at 1 so reset itself is not an accept slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= WIN_W'(1);
        end else if (win_cnt == WIN_LAST) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + WIN_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ddr_ctrl_pkg::ST_IDLE;
            lat_cnt    <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                ddr_ctrl_pkg::ST_IDLE: begin
                    if (accept) begin
                        beats_left <= burstcnt;
                        // Read wins when both lines are raised
                        if (rd) begin
                            lat_cnt <= LAT_LOAD;
                            state   <= ddr_ctrl_pkg::ST_WAIT;
                        end else begin
                            state <= ddr_ctrl_pkg::ST_WRITE;
                        end
                    end
                end
                ddr_ctrl_pkg::ST_WAIT: begin
                    if (lat_cnt == '0) begin
                        state <= ddr_ctrl_pkg::ST_READ;
                    end else begin
                        lat_cnt <= lat_cnt - LAT_W'(1);
                    end
                end
                ddr_ctrl_pkg::ST_WRITE,
                ddr_ctrl_pkg::ST_READ: begin
                    // One beat per cycle until the count runs out
                    if (last_beat) begin
                        state <= ddr_ctrl_pkg::ST_IDLE;
                    end else begin
                        beats_left <= beats_left - ddr_bus_pkg::burst_t'(1);
                    end
                end
                default: begin
                    state <= ddr_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Word pointer, wraps at the top of the array
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr <= addr[`DDR_MEM_AW-1:0];
        end else if (mem_wr || dout_ready) begin
            mem_addr <= mem_addr + ddr_bus_pkg::mem_addr_t'(1);
        end
    end

endmodule

`default_nettype wire

/* src/ddr_burst_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_burst_mem (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rd,
    input  wire                          we,
    input  wire ddr_bus_pkg::addr_t      addr,
    input  wire ddr_bus_pkg::burst_t     burstcnt,
    input  wire ddr_bus_pkg::word_t      din,
    input  wire ddr_bus_pkg::be_t        be,
    output logic                         busy,
    output ddr_bus_pkg::word_t           dout,
    output logic                         dout_ready
);

    ddr_bus_pkg::mem_addr_t mem_addr;
    logic                   mem_wr;

    // Handshake, burst sequencing and read latency
    ddr_burst_ctrl u_ctrl (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .rd         ( rd         ),
        .we         ( we         ),
        .addr       ( addr       ),
        .burstcnt   ( burstcnt   ),
        .busy       ( busy       ),
        .dout_ready ( dout_ready ),
        .mem_addr   ( mem_addr   ),
        .mem_wr     ( mem_wr     )
    );

    // Write data and byte enables go straight to the storage
    ddr_mem_array u_mem (
        .clk      ( clk      ),
        .mem_addr ( mem_addr ),
        .mem_wr   ( mem_wr   ),
        .din      ( din      ),
        .be       ( be       ),
        .dout     ( dout     )
    );

endmodule

`default_nettype wire

/* verification/ddr_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_config.svh"

module ddr_checker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rd,
    input  wire                          we,
    input  wire ddr_bus_pkg::addr_t      addr,
    input  wire ddr_bus_pkg::burst_t     burstcnt,
    input  wire ddr_bus_pkg::word_t      din,
    input  wire ddr_bus_pkg::be_t        be,
    input  wire                          busy,
    input  wire ddr_bus_pkg::word_t      dout,
    input  wire                          dout_ready,
    output int                           value_errs,
    output int                           other_errs
);

    localparam int DEPTH = 1 << `DDR_MEM_AW;

    // Reference memory, only words that have been written exist
    ddr_bus_pkg::word_t        ref_mem [int];
    ddr_ctrl_pkg::ctrl_state_t exp_state;
    int                        win_cnt;
    int                        lat_edges;
    int                        beats_left;
    int                        ptr;
    logic                      exp_busy;
    logic                      exp_ready;

    initial begin
        value_errs = 0;
        other_errs = 0;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        value_errs++;
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
    endtask

    // Byte lane i of the mask covers bits 8*i to 8*i+7
    function automatic ddr_bus_pkg::word_t merge_bytes(input ddr_bus_pkg::word_t old_w,
                                                       input ddr_bus_pkg::word_t new_w,
                                                       input ddr_bus_pkg::be_t mask);
        ddr_bus_pkg::word_t lanes;
        lanes = '0;
        for (int i = 0; i < `DDR_BE_W; i++) begin
            lanes = lanes | ({{(`DDR_WORD_W-8){1'b0}}, {8{mask[i]}}} << (8 * i));
        end
        return (old_w & ~lanes) | (new_w & lanes);
    endfunction

    // Model sampled on the rising edge, before the DUT registers update
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_state  = ddr_ctrl_pkg::ST_IDLE;
            win_cnt    = 1;
            lat_edges  = 0;
            beats_left = 0;
            ptr        = 0;
        end else begin
            exp_busy  = !((exp_state == ddr_ctrl_pkg::ST_IDLE) && (win_cnt == 0));
            exp_ready = (exp_state == ddr_ctrl_pkg::ST_READ);
            if (busy !== exp_busy) begin
                report_mismatch("busy", 64'(exp_busy), 64'(busy));
            end
            if (dout_ready !== exp_ready) begin
                report_mismatch("dout_ready", 64'(exp_ready), 64'(dout_ready));
            end
            if (exp_ready) begin
                if (!ref_mem.exists(ptr)) begin
                    other_errs++;
                    $display("Read of word %0d at %0t, which was never written", ptr, $time);
                end else if (dout !== ref_mem[ptr]) begin
                    report_mismatch("dout", ref_mem[ptr], dout);
                end
            end

            case (exp_state)
                ddr_ctrl_pkg::ST_IDLE: begin
                    if (!exp_busy && (rd || we)) begin
                        ptr        = int'(addr) % DEPTH;
                        beats_left = int'(burstcnt);
                        lat_edges  = 0;
                        if (burstcnt == '0) begin
                            other_errs++;
                            $display("Burst of zero length requested at %0t", $time);
                        end
                        exp_state = rd ? ddr_ctrl_pkg::ST_WAIT : ddr_ctrl_pkg::ST_WRITE;
                    end
                end
                ddr_ctrl_pkg::ST_WAIT: begin
                    lat_edges++;
                    if (lat_edges == `DDR_READ_LATENCY) begin
                        exp_state = ddr_ctrl_pkg::ST_READ;
                    end
                end
                default: begin
                    // Write and read beats both walk the word pointer
                    if (exp_state == ddr_ctrl_pkg::ST_WRITE) begin
                        ref_mem[ptr] = merge_bytes(ref_mem.exists(ptr) ? ref_mem[ptr] : '0,
                                                   din, be);
                    end
                    ptr = (ptr + 1) % DEPTH;
                    beats_left--;
                    if (beats_left <= 0) begin
                        exp_state = ddr_ctrl_pkg::ST_IDLE;
                    end
                end
            endcase
            win_cnt = (win_cnt + 1) % `DDR_ACCEPT_PERIOD;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_ddr_burst_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ddr_config.svh"

module tb_ddr_burst_mem;

    localparam int NUM_OPS      = 11;
    localparam int SLOT_TIMEOUT = 64;
    localparam int READ_TIMEOUT = `DDR_READ_LATENCY + 300;

    // Table row with operation, address, length, byte enables and an extra request while busy
    typedef struct packed {
        logic                is_read;
        ddr_bus_pkg::addr_t  addr;
        ddr_bus_pkg::burst_t len;
        ddr_bus_pkg::be_t    be;
        logic                poke_busy;
    } op_t;

    logic                clk;
    logic                rst_n;
    logic                rd;
    logic                we;
    ddr_bus_pkg::addr_t  addr;
    ddr_bus_pkg::burst_t burstcnt;
    ddr_bus_pkg::word_t  din;
    ddr_bus_pkg::be_t    be;
    logic                busy;
    ddr_bus_pkg::word_t  dout;
    logic                dout_ready;

    int  chk_value_errs;
    int  chk_other_errs;
    int  timeout_errs;
    int  beat_errs;
    bit  timed_out;
    op_t ops [NUM_OPS];

    ddr_burst_mem dut_i (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .rd         ( rd         ),
        .we         ( we         ),
        .addr       ( addr       ),
        .burstcnt   ( burstcnt   ),
        .din        ( din        ),
        .be         ( be         ),
        .busy       ( busy       ),
        .dout       ( dout       ),
        .dout_ready ( dout_ready )
    );

    ddr_checker chk_i (
        .clk        ( clk            ),
        .rst_n      ( rst_n          ),
        .rd         ( rd             ),
        .we         ( we             ),
        .addr       ( addr           ),
        .burstcnt   ( burstcnt       ),
        .din        ( din            ),
        .be         ( be             ),
        .busy       ( busy           ),
        .dout       ( dout           ),
        .dout_ready ( dout_ready     ),
        .value_errs ( chk_value_errs ),
        .other_errs ( chk_other_errs )
    );

    always #10 clk = ~clk;

    task automatic load_table();
        // Single-beat round trip
        ops[0]  = '{1'b0, 29'd5,    8'd1, 8'hFF, 1'b0};
        ops[1]  = '{1'b1, 29'd5,    8'd1, 8'h00, 1'b0};
        // 8-beat bursts and a read raised while busy
        ops[2]  = '{1'b0, 29'd100,  8'd8, 8'hFF, 1'b0};
        ops[3]  = '{1'b1, 29'd100,  8'd8, 8'h00, 1'b1};
        // Partial merge over word 102
        ops[4]  = '{1'b0, 29'd102,  8'd1, 8'h0F, 1'b0};
        ops[5]  = '{1'b1, 29'd100,  8'd8, 8'h00, 1'b0};
        // Wrap past word 1023 and aliased reads
        ops[6]  = '{1'b0, 29'd1020, 8'd8, 8'hFF, 1'b0};
        ops[7]  = '{1'b1, 29'd2044, 8'd8, 8'h00, 1'b0};
        ops[8]  = '{1'b1, 29'd5125, 8'd1, 8'h00, 1'b1};
        ops[9]  = '{1'b0, 29'd2,    8'd2, 8'hA5, 1'b0};
        ops[10] = '{1'b1, 29'd0,    8'd4, 8'h00, 1'b0};
    endtask

    // Returns on the falling edge just before an accept slot
    task automatic wait_for_slot(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < SLOT_TIMEOUT) begin
            @(negedge clk);
            if (!busy) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!ok) begin
            $display("Timeout at %0t: busy never dropped for an accept slot", $time);
        end
    endtask

    task automatic write_burst(input op_t op);
        @(negedge clk);
        we = 1'b0;
        for (int k = 0; k < int'(op.len); k++) begin
            din = {$urandom, $urandom};
            be  = op.be;
            @(negedge clk);
        end
        be = '0;
    endtask

    task automatic read_burst(input op_t op);
        int cycles;
        int beats;
        bit seen_end;
        cycles   = 0;
        beats    = 0;
        seen_end = 1'b0;
        @(negedge clk);
        rd = 1'b0;
        while (!seen_end && cycles < READ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // Window slot inside the latency wait where only the state holds busy high
            if (op.poke_busy && cycles == `DDR_ACCEPT_PERIOD - 1) begin
                rd       = 1'b1;
                addr     = op.addr + 29'd7;
                burstcnt = 8'd2;
            end else begin
                rd = 1'b0;
            end
            if (dout_ready) begin
                beats++;
            end else if (beats > 0) begin
                seen_end = 1'b1;
            end
        end
        if (!seen_end) begin
            timeout_errs++;
            timed_out = 1'b1;
            $display("Timeout at %0t: read burst at %0h did not finish", $time, op.addr);
        end else if (beats != int'(op.len)) begin
            beat_errs++;
            $display("Read burst at %0h gave %0d beats instead of %0d", op.addr, beats, op.len);
        end
    endtask

    task automatic run_op(input op_t op);
        bit ok;
        wait_for_slot(ok);
        if (!ok) begin
            timeout_errs++;
            timed_out = 1'b1;
        end else begin
            addr     = op.addr;
            burstcnt = op.len;
            rd       = op.is_read;
            we       = !op.is_read;
            if (op.is_read) begin
                read_burst(op);
            end else begin
                write_burst(op);
            end
        end
    endtask

    initial begin
        int total;
        clk          = 1'b0;
        rst_n        = 1'b0;
        rd           = 1'b0;
        we           = 1'b0;
        addr         = '0;
        burstcnt     = '0;
        din          = '0;
        be           = '0;
        timeout_errs = 0;
        beat_errs    = 0;
        timed_out    = 1'b0;
        void'($urandom(56963));
        load_table();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_OPS; i++) begin
            if (!timed_out) begin
                run_op(ops[i]);
            end
        end
        repeat (4) @(negedge clk);

        total = chk_value_errs + chk_other_errs + timeout_errs + beat_errs;
        $display("Error counts: value %0d, protocol %0d, beat count %0d, timeout %0d",
                 chk_value_errs, chk_other_errs, beat_errs, timeout_errs);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/ddr_bus_pkg.sv
src/ddr_ctrl_pkg.sv
src/ddr_mem_array.sv
src/ddr_burst_ctrl.sv
src/ddr_burst_mem.sv
verification/ddr_checker.sv
verification/tb_ddr_burst_mem.sv
